/* mem_map_pkg.sv */
/*
 * Memory map package
 * Bus word, address and lane types, transfer size encoding,
 * bus request and graphics port structs, region constants
 */
package mem_map_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  byte_en_t;             // One enable per byte lane

    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'd0,
        MEM_SIZE_HALF = 2'd1,
        MEM_SIZE_WORD = 2'd2
    } mem_size_t;

    typedef struct packed {
        addr_t     addr;
        mem_size_t size;
        logic      write;
    } bus_req_t;

    localparam logic [7:0] REGION_PALETTE     = 8'h05;
    localparam logic [7:0] REGION_OAM         = 8'h07;
    localparam addr_t      PALETTE_OBJ_OFFSET = 32'h0000_0200;

    localparam int PALETTE_WORDS = 128;         // Per palette half
    localparam int OAM_WORDS     = 256;
    localparam int PAL_AW        = $clog2(PALETTE_WORDS);
    localparam int OAM_AW        = $clog2(OAM_WORDS);

    typedef logic [PAL_AW-1:0] pal_index_t;
    typedef logic [OAM_AW-1:0] oam_index_t;

    // Word indices from the graphics pipeline
    typedef struct packed {
        pal_index_t palette_bg;
        pal_index_t palette_obj;
        oam_index_t oam;
    } gfx_addr_t;

    typedef struct packed {
        word_t palette_bg;
        word_t palette_obj;
        word_t oam;
    } gfx_data_t;

endpackage

/* io_reg_pkg.sv */
/*
 * IO register package
 * Register window base and count, register index type,
 * fixed register indices, sound FIFO depth and count type
 */
package io_reg_pkg;

    localparam logic [31:0] IO_BASE     = 32'h0400_0000;
    localparam int          NUM_IO_REGS = 8;
    localparam int          IO_IDX_W    = $clog2(NUM_IO_REGS);

    typedef logic [IO_IDX_W-1:0] io_index_t;

    // Indices 3 and up are plain read/write registers
    localparam io_index_t KEYINPUT_IDX = 3'd0;  // Low half reads buttons
    localparam io_index_t IE_IF_IDX    = 3'd1;  // IE low, IF high
    localparam io_index_t FIFO_A_IDX   = 3'd2;  // Direct sound FIFO port

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    typedef logic [3:0]  fifo_count_t;          // Holds 0 to FIFO_DEPTH
    typedef logic [15:0] half_t;

endpackage

/* dual_port_ram.sv */
/*
 * Dual port word RAM
 * Port A: byte-enabled bus write, registered write-first read
 * Port B: registered read for the graphics pipeline
 */
`timescale 1ns/1ps

module dual_port_ram
    import mem_map_pkg::*;
#(
    parameter int DEPTH = 128
) (
    input  logic                     clock,
    input  logic [$clog2(DEPTH)-1:0] bus_index,
    input  byte_en_t                 byte_we,
    input  word_t                    wdata,
    output word_t                    bus_rdata,
    input  logic [$clog2(DEPTH)-1:0] gfx_index,
    output word_t                    gfx_rdata
);

    word_t mem [DEPTH];
    word_t merged;

    // Old word with the enabled lanes replaced
    always_comb begin
        merged = mem[bus_index];
        for (int b = 0; b < 4; b++) begin
            if (byte_we[b]) merged[8*b +: 8] = wdata[8*b +: 8];
        end
    end

    always_ff @(posedge clock) begin
        if (|byte_we) mem[bus_index] <= merged;
        bus_rdata <= merged;                    // Write first
        gfx_rdata <= mem[gfx_index];
    end

endmodule

/* sound_fifo.sv */
/*
 * Direct sound FIFO
 * Eight-entry word circular buffer with head output, entry count,
 * pop and synchronous clear; push to a full buffer is dropped
 */
`timescale 1ns/1ps

module sound_fifo
    import mem_map_pkg::*, io_reg_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        push,
    input  logic        pop,
    input  logic        clear,
    input  word_t       wdata,
    output word_t       head,
    output fifo_count_t count
);

    word_t                 entries [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] get_ptr, put_ptr;
    logic                  full, empty;
    logic                  do_push, do_pop;

    assign full    = count == fifo_count_t'(FIFO_DEPTH);
    assign empty   = count == '0;
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            get_ptr <= '0;
            put_ptr <= '0;
            count   <= '0;
        end else if (clear) begin
            get_ptr <= '0;
            put_ptr <= '0;
            count   <= '0;
        end else begin
            if (do_push) put_ptr <= put_ptr + 1'b1;
            if (do_pop)  get_ptr <= get_ptr + 1'b1;
            count <= count + fifo_count_t'(do_push) - fifo_count_t'(do_pop);
        end
    end

    always_ff @(posedge clock) begin
        if (do_push && !clear) entries[put_ptr] <= wdata;
    end

    assign head = entries[get_ptr];     // Valid while not empty

endmodule

/* bus_write_stage.sv */
/*
 * Bus write stage
 * Delays the bus request by one cycle, pauses the master for
 * one cycle after an accepted write, decodes byte lane enables
 * and picks the RAM address
 */
`timescale 1ns/1ps

module bus_write_stage
    import mem_map_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  bus_req_t bus_req,
    output logic     bus_pause,
    output bus_req_t req_lat,
    output byte_en_t byte_we,
    output addr_t    mem_addr
);

    logic     accept;
    bus_req_t req_next;
    byte_en_t lanes;

    assign accept = bus_req.write & ~bus_pause;     // Held write is not taken twice

    always_comb begin
        req_next       = bus_req;
        req_next.write = accept;
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            req_lat   <= '0;
            bus_pause <= 1'b0;
        end else begin
            req_lat   <= req_next;
            bus_pause <= accept;
        end
    end

    // Data already sits in its lanes
    always_comb begin
        case (req_lat.size)
            MEM_SIZE_BYTE: lanes = 4'b0001 << req_lat.addr[1:0];
            MEM_SIZE_HALF: lanes = req_lat.addr[1] ? 4'b1100 : 4'b0011;
            default:       lanes = 4'b1111;
        endcase
    end

    assign byte_we = req_lat.write ? lanes : 4'b0000;

    // Delayed address only while the write commits
    assign mem_addr = req_lat.write ? req_lat.addr : bus_req.addr;

endmodule

/* video_mem.sv */
/*
 * Video memory
 * Background palette, object palette and OAM RAMs,
 * region decode from the delayed address, per-region lane gating,
 * bus read select and graphics read ports
 */
`timescale 1ns/1ps

module video_mem
    import mem_map_pkg::*;
(
    input  logic      clock,
    input  bus_req_t  req_lat,
    input  addr_t     mem_addr,
    input  byte_en_t  byte_we,
    input  word_t     wdata,
    input  gfx_addr_t gfx_addr,
    output gfx_data_t gfx_data,
    output word_t     rdata,
    output logic      hit
);

    logic [23:0] region_off;
    logic        in_pal_bg, in_pal_obj, in_oam;
    addr_t       obj_addr;
    byte_en_t    pal_bg_we, pal_obj_we, oam_we;
    word_t       pal_bg_rdata, pal_obj_rdata, oam_rdata;

    // Same decode gates writes and selects reads
    assign region_off = req_lat.addr[23:0];
    assign in_pal_bg  = (req_lat.addr[31:24] == REGION_PALETTE) &&
                        (region_off < PALETTE_OBJ_OFFSET);
    assign in_pal_obj = (req_lat.addr[31:24] == REGION_PALETTE) &&
                        (region_off >= PALETTE_OBJ_OFFSET) &&
                        (region_off < 2 * PALETTE_OBJ_OFFSET);
    assign in_oam     = (req_lat.addr[31:24] == REGION_OAM) &&
                        (region_off < 4 * OAM_WORDS);

    assign pal_bg_we  = in_pal_bg  ? byte_we : 4'b0000;
    assign pal_obj_we = in_pal_obj ? byte_we : 4'b0000;
    assign oam_we     = in_oam     ? byte_we : 4'b0000;

    assign obj_addr = mem_addr - PALETTE_OBJ_OFFSET;    // Object palette starts at zero

    dual_port_ram #(.DEPTH(PALETTE_WORDS)) palette_bg (
        .clock, .bus_index(mem_addr[PAL_AW+1:2]), .byte_we(pal_bg_we), .wdata,
        .bus_rdata(pal_bg_rdata), .gfx_index(gfx_addr.palette_bg),
        .gfx_rdata(gfx_data.palette_bg)
    );

    dual_port_ram #(.DEPTH(PALETTE_WORDS)) palette_obj (
        .clock, .bus_index(obj_addr[PAL_AW+1:2]), .byte_we(pal_obj_we), .wdata,
        .bus_rdata(pal_obj_rdata), .gfx_index(gfx_addr.palette_obj),
        .gfx_rdata(gfx_data.palette_obj)
    );

    dual_port_ram #(.DEPTH(OAM_WORDS)) oam (
        .clock, .bus_index(mem_addr[OAM_AW+1:2]), .byte_we(oam_we), .wdata,
        .bus_rdata(oam_rdata), .gfx_index(gfx_addr.oam), .gfx_rdata(gfx_data.oam)
    );

    assign hit = in_pal_bg | in_pal_obj | in_oam;

    always_comb begin
        if (in_pal_bg)       rdata = pal_bg_rdata;
        else if (in_pal_obj) rdata = pal_obj_rdata;
        else if (in_oam)     rdata = oam_rdata;
        else                 rdata = '0;
    end

endmodule

/* io_regs.sv */
/*
 * IO register block
 * Byte-writable register file, key input and interrupt registers,
 * interrupt acknowledge pulse, direct sound FIFO push and read
 */
`timescale 1ns/1ps

module io_regs
    import mem_map_pkg::*, io_reg_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  bus_req_t    req_lat,
    input  byte_en_t    byte_we,
    input  word_t       wdata,
    input  half_t       buttons,
    input  half_t       irq_flags,
    output half_t       int_acks,
    input  logic        fifo_pop,
    input  logic        fifo_clear,
    output word_t       fifo_head,
    output fifo_count_t fifo_count,
    output word_t       rdata,
    output logic        hit
);

    word_t     regs [NUM_IO_REGS];
    addr_t     io_off;
    io_index_t idx;
    byte_en_t  reg_we, wmask;
    logic      fifo_push;
    word_t     reg_val;

    // Lanes backed by storage; the rest read live inputs
    function automatic byte_en_t lane_mask(io_index_t i);
        case (i)
            KEYINPUT_IDX: return 4'b1100;
            IE_IF_IDX:    return 4'b0011;
            FIFO_A_IDX:   return 4'b0000;
            default:      return 4'b1111;
        endcase
    endfunction

    assign io_off = req_lat.addr - IO_BASE;
    assign hit    = io_off < 4 * NUM_IO_REGS;
    assign idx    = io_off[IO_IDX_W+1:2];
    assign reg_we = hit ? byte_we : 4'b0000;
    assign wmask  = reg_we & lane_mask(idx);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_IO_REGS; i++) regs[i] <= '0;
            int_acks <= '0;
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) regs[idx][8*b +: 8] <= wdata[8*b +: 8];
            end
            // Acknowledge lasts one cycle after the commit
            if (idx == IE_IF_IDX)
                int_acks <= {reg_we[3] ? wdata[31:24] : 8'h00,
                             reg_we[2] ? wdata[23:16] : 8'h00};
            else
                int_acks <= '0;
        end
    end

    assign fifo_push = reg_we[0] && (idx == FIFO_A_IDX);

    sound_fifo fifo_a (
        .clock, .reset, .push(fifo_push), .pop(fifo_pop), .clear(fifo_clear),
        .wdata, .head(fifo_head), .count(fifo_count)
    );

    always_comb begin
        case (idx)
            KEYINPUT_IDX: reg_val = {regs[KEYINPUT_IDX][31:16], buttons};
            IE_IF_IDX:    reg_val = {irq_flags, regs[IE_IF_IDX][15:0]};
            FIFO_A_IDX:   reg_val = fifo_head;
            default:      reg_val = regs[idx];
        endcase
    end

    assign rdata = hit ? reg_val : '0;

endmodule

/* bus_read_mux.sv */
/*
 * Bus read combiner
 * Video before IO, zero when unmapped; replays the CPU read word
 * preempted by a DMA transfer in the cycle after it ends
 */
`timescale 1ns/1ps

module bus_read_mux
    import mem_map_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  dma_active,
    input  word_t vid_rdata,
    input  word_t io_rdata,
    input  logic  vid_hit,
    input  logic  io_hit,
    output word_t bus_rdata
);

    logic  dma_q;
    logic  dma_rise, dma_fall;
    word_t live_rdata;
    word_t held_rdata;      // CPU word at DMA start

    always_comb begin
        if (vid_hit)     live_rdata = vid_rdata;
        else if (io_hit) live_rdata = io_rdata;
        else             live_rdata = '0;
    end

    assign dma_rise = dma_active & ~dma_q;
    assign dma_fall = ~dma_active & dma_q;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            dma_q      <= 1'b0;
            held_rdata <= '0;
        end else begin
            dma_q <= dma_active;
            if (dma_rise) held_rdata <= bus_rdata;
        end
    end

    assign bus_rdata = dma_fall ? held_rdata : live_rdata;

endmodule

/* mem_ctrl_top.sv */
/*
 * Memory controller top level
 * Write stage feeding video memory and IO registers side by side,
 * read combiner merging their results onto the bus
 */
`timescale 1ns/1ps

module mem_ctrl_top
    import mem_map_pkg::*, io_reg_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  bus_req_t    bus_req,
    input  word_t       bus_wdata,
    output word_t       bus_rdata,
    output logic        bus_pause,
    input  logic        dma_active,
    input  gfx_addr_t   gfx_addr,
    output gfx_data_t   gfx_data,
    input  half_t       buttons,
    input  half_t       irq_flags,
    output half_t       int_acks,
    input  logic        fifo_pop,
    input  logic        fifo_clear,
    output word_t       fifo_head,
    output fifo_count_t fifo_count
);

    bus_req_t req_lat;
    byte_en_t byte_we;
    addr_t    mem_addr;
    word_t    vid_rdata, io_rdata;
    logic     vid_hit, io_hit;

    bus_write_stage write_stage (
        .clock, .reset, .bus_req, .bus_pause, .req_lat, .byte_we, .mem_addr
    );

    video_mem video (
        .clock, .req_lat, .mem_addr, .byte_we, .wdata(bus_wdata), .gfx_addr,
        .gfx_data, .rdata(vid_rdata), .hit(vid_hit)
    );

    io_regs io (
        .clock, .reset, .req_lat, .byte_we, .wdata(bus_wdata), .buttons,
        .irq_flags, .int_acks, .fifo_pop, .fifo_clear, .fifo_head, .fifo_count,
        .rdata(io_rdata), .hit(io_hit)
    );

    bus_read_mux read_mux (
        .clock, .reset, .dma_active, .vid_rdata, .io_rdata, .vid_hit, .io_hit,
        .bus_rdata
    );

endmodule

/* mem_ctrl_asserts.sv */
/*
 * Concurrent assertions on the memory controller top level
 * Single-cycle pause, acknowledge only after a commit, FIFO count bound
 */
`timescale 1ns/1ps

module mem_ctrl_asserts
    import io_reg_pkg::*;
(
    input logic        clock,
    input logic        reset,
    input logic        bus_pause,
    input half_t       int_acks,
    input fifo_count_t fifo_count
);

    int unsigned failures = 0;      // Count of failed assertions

    a_single_pause: assert property (@(posedge clock) disable iff (reset)
        bus_pause |=> !bus_pause)
        else begin
            failures = failures + 1;
            $error("bus_pause high for two cycles");
        end

    // A commit happens at the end of the pause cycle
    a_acks_after_commit: assert property (@(posedge clock) disable iff (reset)
        (int_acks != '0) |-> $past(bus_pause))
        else begin
            failures = failures + 1;
            $error("int_acks set without a committed write");
        end

    a_fifo_bound: assert property (@(posedge clock) disable iff (reset)
        fifo_count <= fifo_count_t'(FIFO_DEPTH))
        else begin
            failures = failures + 1;
            $error("fifo_count above FIFO depth");
        end

endmodule

bind mem_ctrl_top mem_ctrl_asserts asserts0 (
    .clock, .reset, .bus_pause, .int_acks, .fifo_count
);

/* tb_mem_ctrl.sv */
/*
 * Memory controller testbench
 * Clock and reset, seeded random bus, graphics, IO, FIFO and DMA stimulus,
 * cycle-level reference model, compare tasks per result type, cycle limit
 */
`timescale 1ns/1ps

module tb_mem_ctrl
    import mem_map_pkg::*, io_reg_pkg::*;
;

    localparam int INIT_WRITES    = 2 * PALETTE_WORDS + OAM_WORDS;
    localparam int FIFO_STEPS     = FIFO_DEPTH + 2;
    localparam int RAND_CYCLES    = 4000;
    localparam int PLANNED_CYCLES = 4 + 2 * INIT_WRITES + 3 * FIFO_STEPS + RAND_CYCLES;
    localparam int CYCLE_LIMIT    = 2 * PLANNED_CYCLES;

    logic        clock = 1'b0;
    logic        reset = 1'b1;
    bus_req_t    bus_req;
    word_t       bus_wdata, bus_rdata, fifo_head;
    logic        bus_pause, dma_active, fifo_pop, fifo_clear;
    gfx_addr_t   gfx_addr;
    gfx_data_t   gfx_data;
    half_t       buttons, irq_flags, int_acks;
    fifo_count_t fifo_count;
    int          cycles = 0;

    // Reference model state
    word_t     pal_m [2*PALETTE_WORDS];     // Background half then object half
    word_t     oam_m [OAM_WORDS];
    word_t     regs_m [NUM_IO_REGS];
    word_t     fifo_q [$];
    bus_req_t  lat_m;
    logic      pause_m, dma_q_m, held_known, last_known;
    half_t     acks_m;
    gfx_data_t gfx_m;
    word_t     held_m, last_rd;

    mem_ctrl_top dut0 (
        .clock, .reset, .bus_req, .bus_wdata, .bus_rdata, .bus_pause, .dma_active,
        .gfx_addr, .gfx_data, .buttons, .irq_flags, .int_acks, .fifo_pop,
        .fifo_clear, .fifo_head, .fifo_count
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run exceeded its cycle limit of %0d cycles", CYCLE_LIMIT);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_half(string name, half_t got, half_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(string name, fifo_count_t got, fifo_count_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic byte_en_t lanes_for(bus_req_t r);
        case (r.size)
            MEM_SIZE_BYTE: return 4'b0001 << r.addr[1:0];
            MEM_SIZE_HALF: return r.addr[1] ? 4'b1100 : 4'b0011;
            default:       return 4'b1111;
        endcase
    endfunction

    function automatic word_t merge(word_t old, word_t data, byte_en_t lanes);
        word_t w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) w[8*b +: 8] = data[8*b +: 8];
        end
        return w;
    endfunction

    function automatic logic in_region(addr_t a, logic [7:0] region);
        return a[31:24] == region && a[23:0] < 24'h400;
    endfunction

    // Read value of an address; an empty FIFO has no defined head
    function automatic word_t model_read(addr_t a, output logic known);
        addr_t off;
        off = a - IO_BASE;
        known = 1'b1;
        if (in_region(a, REGION_PALETTE)) return pal_m[a[9:2]];
        if (in_region(a, REGION_OAM))     return oam_m[a[9:2]];
        if (off >= 4 * NUM_IO_REGS)       return '0;
        case (io_index_t'(off[4:2]))
            KEYINPUT_IDX: return {regs_m[0][31:16], buttons};
            IE_IF_IDX:    return {irq_flags, regs_m[1][15:0]};
            FIFO_A_IDX: begin
                known = fifo_q.size() > 0;
                return known ? fifo_q[0] : '0;
            end
            default:      return regs_m[off[4:2]];
        endcase
    endfunction

    task automatic check_outputs();
        word_t exp;
        logic  known;
        @(negedge clock);
        exp = model_read(lat_m.addr, known);
        if (!dma_active && dma_q_m) begin   // Replay after DMA ends
            exp   = held_m;
            known = held_known;
        end
        if (known) check_word("bus_rdata", bus_rdata, exp);
        last_rd    = exp;
        last_known = known;
        check_flag("bus_pause", bus_pause, pause_m);
        check_half("int_acks", int_acks, acks_m);
        check_count("fifo_count", fifo_count, fifo_count_t'(fifo_q.size()));
        if (fifo_q.size() > 0) check_word("fifo_head", fifo_head, fifo_q[0]);
        check_word("gfx_data.palette_bg", gfx_data.palette_bg, gfx_m.palette_bg);
        check_word("gfx_data.palette_obj", gfx_data.palette_obj, gfx_m.palette_obj);
        check_word("gfx_data.oam", gfx_data.oam, gfx_m.oam);
    endtask

    task automatic update_model();
        byte_en_t lanes;
        addr_t    a, off;
        logic     push, empty, full, pause_next;
        @(posedge clock);
        gfx_m.palette_bg  = pal_m[{1'b0, gfx_addr.palette_bg}];    // Reads before commit
        gfx_m.palette_obj = pal_m[{1'b1, gfx_addr.palette_obj}];
        gfx_m.oam         = oam_m[gfx_addr.oam];
        if (dma_active && !dma_q_m) begin
            held_m     = last_rd;
            held_known = last_known;
        end
        dma_q_m = dma_active;
        acks_m  = '0;
        push    = 1'b0;
        if (lat_m.write) begin
            lanes = lanes_for(lat_m);
            a     = lat_m.addr;
            off   = a - IO_BASE;
            if (in_region(a, REGION_PALETTE))  pal_m[a[9:2]] = merge(pal_m[a[9:2]], bus_wdata, lanes);
            else if (in_region(a, REGION_OAM)) oam_m[a[9:2]] = merge(oam_m[a[9:2]], bus_wdata, lanes);
            else if (off < 4 * NUM_IO_REGS) begin
                case (io_index_t'(off[4:2]))
                    KEYINPUT_IDX: regs_m[0] = merge(regs_m[0], bus_wdata, lanes & 4'b1100);
                    IE_IF_IDX: begin
                        regs_m[1] = merge(regs_m[1], bus_wdata, lanes & 4'b0011);
                        acks_m    = {lanes[3] ? bus_wdata[31:24] : 8'h00,
                                     lanes[2] ? bus_wdata[23:16] : 8'h00};
                    end
                    FIFO_A_IDX: push = lanes[0];
                    default:    regs_m[off[4:2]] = merge(regs_m[off[4:2]], bus_wdata, lanes);
                endcase
            end
        end
        empty = fifo_q.size() == 0;
        full  = fifo_q.size() == FIFO_DEPTH;
        if (fifo_clear) begin
            fifo_q.delete();
        end else begin
            if (fifo_pop && !empty) void'(fifo_q.pop_front());
            if (push && !full)      fifo_q.push_back(bus_wdata);
        end
        pause_next  = bus_req.write & ~pause_m;
        lat_m       = bus_req;
        lat_m.write = pause_next;
        pause_m     = pause_next;
        #1;
    endtask

    task automatic run_cycle();
        check_outputs();
        update_model();
    endtask

    task automatic drive_side_inputs();
        gfx_addr   = gfx_addr_t'($urandom);
        buttons    = half_t'($urandom);
        irq_flags  = half_t'($urandom);
        fifo_pop   = $urandom_range(3) == 0;
        fifo_clear = $urandom_range(31) == 0;
        if ($urandom_range(7) == 0) dma_active = ~dma_active;
    endtask

    function automatic addr_t rand_addr(int kind);
        case (kind)
            0:       return {REGION_PALETTE, 24'($urandom_range(24'h3ff))};
            1:       return {REGION_OAM, 24'($urandom_range(24'h3ff))};
            2:       return IO_BASE + addr_t'($urandom_range(4 * NUM_IO_REGS - 1));
            default: return {8'h03, 24'($urandom)};    // Unmapped
        endcase
    endfunction

    initial begin
        int  op;
        logic hold;
        void'($urandom(32'h4bc5_7ec8));
        bus_req    = '0;
        bus_wdata  = '0;
        dma_active = 1'b0;
        gfx_addr   = '0;
        buttons    = '0;
        irq_flags  = '0;
        fifo_pop   = 1'b0;
        fifo_clear = 1'b0;
        foreach (pal_m[i]) pal_m[i] = 'x;   // RAMs power up undefined
        foreach (oam_m[i]) oam_m[i] = 'x;
        foreach (regs_m[i]) regs_m[i] = '0;
        lat_m      = '0;
        pause_m    = 1'b0;
        dma_q_m    = 1'b0;
        acks_m     = '0;
        gfx_m      = 'x;
        held_m     = '0;
        held_known = 1'b1;
        repeat (4) @(posedge clock);
        #1 reset = 1'b0;

        // Fill every palette and OAM word
        for (int i = 0; i < INIT_WRITES; i++) begin
            bus_req.addr  = i < 2 * PALETTE_WORDS ? {REGION_PALETTE, 24'(i * 4)}
                                                  : {REGION_OAM, 24'((i - 256) * 4)};
            bus_req.size  = MEM_SIZE_WORD;
            bus_req.write = 1'b1;
            bus_wdata     = $urandom;
            run_cycle();
            run_cycle();                // Held through the pause
        end

        // Push past the FIFO depth and pop past empty
        for (int i = 0; i < FIFO_STEPS; i++) begin
            bus_req.addr  = IO_BASE + addr_t'(4 * FIFO_A_IDX);
            bus_req.size  = MEM_SIZE_WORD;
            bus_req.write = 1'b1;
            bus_wdata     = $urandom;
            run_cycle();
            run_cycle();
        end
        bus_req.write = 1'b0;
        fifo_pop      = 1'b1;
        repeat (FIFO_STEPS) run_cycle();

        hold = 1'b0;
        repeat (RAND_CYCLES) begin
            drive_side_inputs();
            if (!hold) begin
                op            = $urandom_range(9);
                bus_req.addr  = rand_addr(op < 4 ? $urandom_range(2) : $urandom_range(3));
                bus_req.size  = mem_size_t'($urandom_range(2));
                bus_req.write = op < 4;
                bus_wdata     = $urandom;
                hold          = bus_req.write;
            end else begin
                hold = 1'b0;
            end
            run_cycle();
        end

        if (dut0.asserts0.failures != 0) begin
            $display("Concurrent assertions failed %0d times", dut0.asserts0.failures);
            stop_run();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

/* project.f */
mem_map_pkg.sv
io_reg_pkg.sv
dual_port_ram.sv
sound_fifo.sv
bus_write_stage.sv
video_mem.sv
io_regs.sv
bus_read_mux.sv
mem_ctrl_top.sv
mem_ctrl_asserts.sv
tb_mem_ctrl.sv
